/* mul_arith_pkg.sv */
// datapath widths, the carry-save stage word and prefix cells shared by the multiplier blocks.
package mul_arith_pkg;

  // ########################################
  // widths
  // ########################################

  localparam int OPERAND_W     = 16;
  localparam int PRODUCT_W     = 32;
  localparam int FIRST_CSA_ROW = 2;                   // rows 0 and 1 come from the seed.
  localparam int PREFIX_LEVELS = $clog2(PRODUCT_W);   // log-depth tree.

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;

  // word passed from stage to stage down the array.
  typedef struct packed {
    logic     valid;
    operand_t x;
    operand_t y;
    product_t sum;
    product_t carry;
  } csa_word_t;

  // ########################################
  // prefix cells
  // ########################################

  // black cell, returns {group generate, group propagate}.
  function automatic logic [1:0] prefix_black(input logic g_hi, input logic p_hi,
                                              input logic g_lo, input logic p_lo);
    return {g_hi | (p_hi & g_lo), p_hi & p_lo};
  endfunction

  // grey cell, lower group already reaches bit 0 so only generate is needed.
  function automatic logic prefix_grey(input logic g_hi, input logic p_hi,
                                       input logic g_lo);
    return g_hi | (p_hi & g_lo);
  endfunction

endpackage

/* mul_hs_pkg.sv */
// operand bundle carried across the four-phase input channel of the multiplier.
package mul_hs_pkg;

  // both operands travel together under one req_in.
  typedef struct packed {
    mul_arith_pkg::operand_t x;
    mul_arith_pkg::operand_t y;
  } mul_operands_t;

endpackage

/* pp_seed.sv */
// first pipeline stage, registers partial-product rows 0 and 1 as the initial sum and carry.
`timescale 1ns/10ps

module pp_seed (
  input  logic                     clk,
  input  logic                     rst,
  input  mul_arith_pkg::csa_word_t launch,
  output mul_arith_pkg::csa_word_t seed
);
  import mul_arith_pkg::*;

  product_t row0;
  product_t row1;

  always_comb begin
    row0 = PRODUCT_W'(launch.y & {OPERAND_W{launch.x[0]}});
    // row 1 sits one place up, so it can ride in the carry slot.
    row1 = PRODUCT_W'(launch.y & {OPERAND_W{launch.x[1]}}) << 1;
  end

  always_ff @(posedge clk) begin
    seed.x     <= launch.x;
    seed.y     <= launch.y;
    seed.sum   <= row0;
    seed.carry <= row1;
    if (rst) begin
      seed.valid <= 1'b0;
    end else begin
      seed.valid <= launch.valid;
    end
  end

endmodule

/* csa_stage.sv */
// one registered carry-save row, adds partial product ROW into the running sum and carry.
`timescale 1ns/10ps

module csa_stage #(
  parameter int ROW = mul_arith_pkg::FIRST_CSA_ROW
) (
  input  logic                     clk,
  input  logic                     rst,
  input  mul_arith_pkg::csa_word_t acc_in,
  output mul_arith_pkg::csa_word_t acc_out
);
  import mul_arith_pkg::*;

  product_t row_pp;
  product_t fa_sum;
  product_t fa_cy;

  always_comb begin
    row_pp = PRODUCT_W'(acc_in.y & {OPERAND_W{acc_in.x[ROW]}}) << ROW;
    // a full adder per bit column.
    fa_sum = acc_in.sum ^ acc_in.carry ^ row_pp;
    fa_cy  = (acc_in.sum & acc_in.carry) | (row_pp & (acc_in.sum ^ acc_in.carry));
  end

  always_ff @(posedge clk) begin
    acc_out.x     <= acc_in.x;
    acc_out.y     <= acc_in.y;
    acc_out.sum   <= fa_sum;
    acc_out.carry <= fa_cy << 1;   // carries weigh one column more.
    if (rst) begin
      acc_out.valid <= 1'b0;
    end else begin
      acc_out.valid <= acc_in.valid;
    end
  end

endmodule

/* prefix_adder.sv */
// final registered stage, resolves the carry-save pair into the product with a prefix tree.
`timescale 1ns/10ps

module prefix_adder (
  input  logic                     clk,
  input  logic                     rst,
  input  mul_arith_pkg::csa_word_t acc_in,
  output logic                     sum_valid,
  output mul_arith_pkg::product_t  sum
);
  import mul_arith_pkg::*;

  // group generate and propagate after each tree level.
  logic [PRODUCT_W-1:0] g [PREFIX_LEVELS+1];
  logic [PRODUCT_W-1:0] p [PREFIX_LEVELS+1];
  product_t             carry_in;
  product_t             sum_d;

  // ########################################
  // prefix tree
  // ########################################

  always_comb begin
    g[0] = acc_in.sum & acc_in.carry;
    p[0] = acc_in.sum ^ acc_in.carry;
    for (int l = 0; l < PREFIX_LEVELS; l++) begin
      for (int i = 0; i < PRODUCT_W; i++) begin
        if (i < (1 << l)) begin
          // already complete down to bit 0.
          g[l+1][i] = g[l][i];
          p[l+1][i] = p[l][i];
        end else if (i < (2 << l)) begin
          // lower group reaches bit 0 here.
          g[l+1][i] = prefix_grey(g[l][i], p[l][i], g[l][i-(1<<l)]);
          p[l+1][i] = p[l][i];
        end else begin
          {g[l+1][i], p[l+1][i]} = prefix_black(g[l][i], p[l][i],
                                                g[l][i-(1<<l)], p[l][i-(1<<l)]);
        end
      end
    end
    // carry out of the top bit is dropped, the product fits.
    carry_in = {g[PREFIX_LEVELS][PRODUCT_W-2:0], 1'b0};
    sum_d    = p[0] ^ carry_in;
  end

  // ########################################
  // output register
  // ########################################

  always_ff @(posedge clk) begin
    sum <= sum_d;
    if (rst) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= acc_in.valid;
    end
  end

endmodule

/* mul_handshake.sv */
// four-phase input and output channels, launches one multiplication and holds its product.
`timescale 1ns/10ps

module mul_handshake (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_in,
  output logic                       ack_in,
  input  mul_hs_pkg::mul_operands_t  op_in,
  output mul_arith_pkg::csa_word_t   launch,
  input  logic                       sum_valid,
  input  mul_arith_pkg::product_t    sum,
  output logic                       req_out,
  input  logic                       ack_out,
  output mul_arith_pkg::product_t    product
);

  // idle, computing, offering the result, waiting for ack_out to drop.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_REQ,
    ST_DONE
  } hs_state_t;

  hs_state_t state;
  logic      start;

  // new request, previous input phase finished.
  assign start   = (state == ST_IDLE) && req_in && !ack_in;
  assign req_out = (state == ST_REQ);

  // ########################################
  // control
  // ########################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      ack_in <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (start) state <= ST_CALC;
        ST_CALC: if (sum_valid) state <= ST_REQ;
        ST_REQ:  if (ack_out) state <= ST_DONE;
        ST_DONE: if (!ack_out) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
      if (start) begin
        ack_in <= 1'b1;
      end else if (!req_in) begin
        ack_in <= 1'b0;   // return to zero.
      end
    end
  end

  // ########################################
  // datapath ends
  // ########################################

  always_ff @(posedge clk) begin
    if (start) begin
      launch.x     <= op_in.x;
      launch.y     <= op_in.y;
      launch.sum   <= '0;
      launch.carry <= '0;
    end
    if (rst) begin
      launch.valid <= 1'b0;
    end else begin
      launch.valid <= start;   // one cycle only.
    end
  end

  // held until the next launch completes.
  always_ff @(posedge clk) begin
    if (state == ST_CALC && sum_valid) begin
      product <= sum;
    end
  end

endmodule

/* csa_mul_top.sv */
// top level of the pipelined 16x16 multiplier, seed, carry-save array, prefix adder, handshake.
`timescale 1ns/10ps

module csa_mul_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_in,
  output logic                      ack_in,
  input  mul_hs_pkg::mul_operands_t op_in,
  output logic                      req_out,
  input  logic                      ack_out,
  output mul_arith_pkg::product_t   product
);
  import mul_arith_pkg::*;

  csa_word_t launch;
  csa_word_t acc [FIRST_CSA_ROW:OPERAND_W];   // acc[r] feeds the stage for row r.
  logic      sum_valid;
  product_t  sum;

  mul_handshake i_handshake (
    .clk       (clk),
    .rst       (rst),
    .req_in    (req_in),
    .ack_in    (ack_in),
    .op_in     (op_in),
    .launch    (launch),
    .sum_valid (sum_valid),
    .sum       (sum),
    .req_out   (req_out),
    .ack_out   (ack_out),
    .product   (product)
  );

  pp_seed i_seed (
    .clk    (clk),
    .rst    (rst),
    .launch (launch),
    .seed   (acc[FIRST_CSA_ROW])
  );

  // one registered row per remaining partial product.
  for (genvar r = FIRST_CSA_ROW; r < OPERAND_W; r++) begin : g_row
    csa_stage #(
      .ROW (r)
    ) i_stage (
      .clk     (clk),
      .rst     (rst),
      .acc_in  (acc[r]),
      .acc_out (acc[r+1])
    );
  end

  prefix_adder i_adder (
    .clk       (clk),
    .rst       (rst),
    .acc_in    (acc[OPERAND_W]),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

endmodule

/* tb_csa_mul.sv */
// testbench for csa_mul_top that drives both four-phase channels and checks products and timing.
`timescale 1ns/10ps

module tb_csa_mul;
  import mul_arith_pkg::*;
  import mul_hs_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 8;
  localparam int LATENCY      = 17;      // ack_in rise to req_out rise.
  localparam int N_RANDOM     = 200;
  localparam int MAX_CYCLES   = 10000;   // 240 ops at about 35 cycles plus margin.

  logic          clk;
  logic          rst;
  logic          req_in;
  logic          ack_in;
  mul_operands_t op_in;
  logic          req_out;
  logic          ack_out;
  product_t      product;

  logic [31:0] lcg_state = 32'hf19f82db;
  product_t    expected_q[$];   // one entry per request in order of issue.
  int          delay_q[$];      // ack_out delay for each result.
  int          cycle = 0;
  int          n_results = 0;
  int          ack_rise_cycle = 0;
  logic        req_seen = 1'b0;
  logic        awaiting = 1'b0;   // launched and output handshake not yet over.
  logic        offered = 1'b0;
  logic        prev_ack_in = 1'b0;
  logic        prev_req_in = 1'b0;
  logic        prev_req_out = 1'b0;
  logic        prev_ack_out = 1'b0;
  product_t    held_product = '0;

  csa_mul_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .req_in  (req_in),
    .ack_in  (ack_in),
    .op_in   (op_in),
    .req_out (req_out),
    .ack_out (ack_out),
    .product (product)
  );

  // ########################################
  // helpers
  // ########################################

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    $display("** Error: %s = %h, expected %h at cycle %0d", name, got, expected, cycle);
    $display("TEST FAILED");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic protocol_error(input string msg);
    $display("%s at cycle %0d", msg, cycle);
    $display("TEST FAILED");
    $fatal(1, "handshake check failed");
  endtask

  // one full input handshake with the expected product queued at request time.
  task automatic send_op(input operand_t x, input operand_t y);
    logic [31:0] r;
    r = next_rand();
    delay_q.push_back({29'd0, r[31:29]});
    @(posedge clk);
    #DRIVE_DELAY;
    op_in.x = x;
    op_in.y = y;
    req_in  = 1'b1;
    expected_q.push_back(product_t'(x) * product_t'(y));
    while (!ack_in) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    req_in = 1'b0;
    while (ack_in) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  // ########################################
  // clock and timeout
  // ########################################

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, handshake never completed", cycle);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // ########################################
  // stimulus
  // ########################################

  initial begin : stimulus
    logic [31:0] r;
    operand_t    x;
    operand_t    y;
    rst    = 1'b1;
    req_in = 1'b0;
    op_in  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    repeat (3) @(posedge clk);   // idle so outputs must stay low.

    send_op(16'h0000, 16'h1234);
    send_op(16'hbeef, 16'h0000);
    send_op(16'hffff, 16'hffff);
    send_op(16'h0001, 16'ha5c3);
    send_op(16'h7e91, 16'h0001);
    for (int i = 0; i < OPERAND_W; i++) begin
      send_op(operand_t'(1) << i, operand_t'(1) << i);
      send_op(operand_t'(1) << i, operand_t'(1) << (OPERAND_W - 1 - i));
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      r = next_rand();
      x = r[31:16];
      r = next_rand();
      y = r[31:16];
      send_op(x, y);
    end

    while (awaiting) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);   // room for a stray extra result.
    $display("TEST OK");
    $finish;
  end

  // output side raises ack_out after a random number of cycles.
  initial begin : output_side
    int delay;
    int n_taken;
    ack_out = 1'b0;
    n_taken = 0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (req_out) begin
        delay = 0;
        if (n_taken < delay_q.size()) begin
          delay = delay_q[n_taken];
        end
        n_taken++;
        repeat (delay) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        ack_out = 1'b1;
        while (req_out) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        ack_out = 1'b0;
      end
    end
  end

  // ########################################
  // checks sampled mid-cycle
  // ########################################

  always @(negedge clk) begin
    if (!rst) begin
      if (!req_seen) begin
        assert (!ack_in && !req_out)
          else protocol_error("ack_in or req_out high before the first request");
      end
      if (ack_in && !prev_ack_in) begin
        assert (prev_req_in) else protocol_error("ack_in rose without req_in");
        assert (!awaiting)
          else protocol_error("ack_in rose before the previous output handshake ended");
        ack_rise_cycle = cycle;
        awaiting       = 1'b1;
      end
      if (!ack_in && prev_ack_in) begin
        assert (!prev_req_in) else protocol_error("ack_in fell while req_in was high");
      end
      if (req_out && !prev_req_out) begin
        assert (n_results < expected_q.size())
          else protocol_error("result offered with no request pending");
        assert (cycle - ack_rise_cycle == LATENCY)
          else value_error("latency", cycle - ack_rise_cycle, LATENCY);
        assert (product == expected_q[n_results])
          else value_error("product", product, expected_q[n_results]);
        held_product = product;
        offered      = 1'b1;
        n_results++;
      end
      if (req_out && prev_req_out) begin
        assert (product == held_product) else value_error("product", product, held_product);
      end
      if (!req_out && prev_req_out) begin
        assert (prev_ack_out) else protocol_error("req_out fell before ack_out was high");
      end
      if (offered && !req_out && !ack_out) begin
        offered  = 1'b0;   // output handshake over.
        awaiting = 1'b0;
      end
      if (req_in) begin
        req_seen = 1'b1;
      end
    end
    prev_ack_in  = ack_in;
    prev_req_in  = req_in;
    prev_req_out = req_out;
    prev_ack_out = ack_out;
  end

endmodule

/* csa_mul.f */
mul_arith_pkg.sv
mul_hs_pkg.sv
pp_seed.sv
csa_stage.sv
prefix_adder.sv
mul_handshake.sv
csa_mul_top.sv
tb_csa_mul.sv

/* Makefile */
# Verilator build for the csa_mul multiplier and its testbench.

TOP := tb_csa_mul

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): csa_mul.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  -f csa_mul.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
	  -f csa_mul.f --top-module $(TOP)

clean:
	rm -rf obj_dir
